// File: rtl/simproc_config.svh
`ifndef SIMPROC_CONFIG_SVH
`define SIMPROC_CONFIG_SVH

// Datapath word width
`define SIMPROC_DATA_WIDTH 8

// Memory address width and depth
`define SIMPROC_ADDR_WIDTH 8
`define SIMPROC_MEM_DEPTH  256

// General purpose registers
`define SIMPROC_NUM_REGS   4

`endif

// File: rtl/simproc_pkg.sv
`default_nettype none

`include "simproc_config.svh"

package simproc_pkg;

    // One data byte, also used for addresses and the PC
    typedef logic [`SIMPROC_DATA_WIDTH-1:0] word_t;

    typedef logic [$clog2(`SIMPROC_NUM_REGS)-1:0] reg_idx_t;

    // Instruction opcodes in the low nibble of the instruction
    // ORI and SHIFT only decode their low 3 bits
    typedef enum logic [3:0] {
        OP_LOAD  = 4'b0000,
        OP_JUMP  = 4'b0001,
        OP_STORE = 4'b0010,
        OP_SHIFT = 4'b0011,
        OP_ADD   = 4'b0100,
        OP_BPZ   = 4'b0101,
        OP_SUB   = 4'b0110,
        OP_ORI   = 4'b0111,
        OP_NAND  = 4'b1000,
        OP_BNZ   = 4'b1001,
        OP_BZ    = 4'b1010
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_OR   = 3'b010,
        ALU_NAND = 3'b011,
        ALU_SHL  = 3'b100,
        ALU_SHR  = 3'b101
    } alu_op_t;

    typedef enum logic [2:0] {
        IDLE,
        CYCLE_1,
        CYCLE_2,
        CYCLE_3,
        CYCLE_4,
        CYCLE_5
    } core_state_t;

endpackage

`default_nettype wire

// File: rtl/simproc_if.sv
`default_nettype none
`timescale 1ns/1ps

// Processor side of the shared memory
interface mem_port_if;
    simproc_pkg::word_t addr;
    simproc_pkg::word_t din;
    logic               we;
    simproc_pkg::word_t dout;

    modport core (
        output addr, din, we,
        input  dout
    );

    modport memory (
        input  addr, din, we,
        output dout
    );
endinterface

// Two read ports and one write port of the register file
interface rf_port_if;
    simproc_pkg::reg_idx_t idx_a;
    simproc_pkg::reg_idx_t idx_b;
    simproc_pkg::reg_idx_t idx_w;
    simproc_pkg::word_t    wdata;
    logic                  we;
    simproc_pkg::word_t    rdata_a;
    simproc_pkg::word_t    rdata_b;

    modport core (
        output idx_a, idx_b, idx_w, wdata, we,
        input  rdata_a, rdata_b
    );

    modport regfile (
        input  idx_a, idx_b, idx_w, wdata, we,
        output rdata_a, rdata_b
    );
endinterface

`default_nettype wire

// File: rtl/dp_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "simproc_config.svh"

module dp_ram (
    input  wire logic                           clk,
    mem_port_if.memory                          mem,
    input  wire logic [`SIMPROC_ADDR_WIDTH-1:0] host_addr,
    input  wire logic [`SIMPROC_DATA_WIDTH-1:0] host_din,
    input  wire logic                           host_we,
    output logic      [`SIMPROC_DATA_WIDTH-1:0] host_dout
);

    logic [`SIMPROC_DATA_WIDTH-1:0] ram [`SIMPROC_MEM_DEPTH];

    // Port A is the processor, port B the host
    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.din;
        end
        if (host_we) begin
            ram[host_addr] <= host_din;
        end
    end

    // Asynchronous reads on both ports
    always_comb begin
        mem.dout  = ram[mem.addr];
        host_dout = ram[host_addr];
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`default_nettype none
`timescale 1ns/1ps

`include "simproc_config.svh"

module register_file (
    input  wire logic  clk,
    input  wire logic  rst,
    rf_port_if.regfile rf
);

    simproc_pkg::word_t regs [`SIMPROC_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SIMPROC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (rf.we) begin
            regs[rf.idx_w] <= rf.wdata;
        end
    end

    // Read ports see the old value during a write cycle
    always_comb begin
        rf.rdata_a = regs[rf.idx_a];
        rf.rdata_b = regs[rf.idx_b];
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  wire simproc_pkg::alu_op_t op,
    input  wire simproc_pkg::word_t   a,
    input  wire simproc_pkg::word_t   b,
    output simproc_pkg::word_t        result,
    output logic                      n,
    output logic                      z
);

    always_comb begin
        case (op)
            simproc_pkg::ALU_ADD:  result = a + b;
            simproc_pkg::ALU_SUB:  result = a - b;
            simproc_pkg::ALU_OR:   result = a | b;
            simproc_pkg::ALU_NAND: result = ~(a & b);
            // Shift amount is limited to 0..3
            simproc_pkg::ALU_SHL:  result = a << b[1:0];
            simproc_pkg::ALU_SHR:  result = a >> b[1:0];
            default:               result = '0;
        endcase
    end

    // Flags from the result
    always_comb begin
        n = result[$bits(result)-1];
        z = (result == '0);
    end

endmodule

`default_nettype wire

// File: rtl/simproc_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "simproc_config.svh"

module simproc_core (
    input  wire logic                 clk,
    input  wire logic                 rst,
    mem_port_if.core                  mem,
    rf_port_if.core                   rf,
    output simproc_pkg::alu_op_t      alu_op,
    output simproc_pkg::word_t        alu_a,
    output simproc_pkg::word_t        alu_b,
    input  wire simproc_pkg::word_t   alu_result,
    input  wire logic                 alu_n,
    input  wire logic                 alu_z,
    input  wire simproc_pkg::word_t   pc_set_val,
    input  wire logic                 pc_set_wr,
    input  wire logic                 run,
    output simproc_pkg::word_t        pc,
    output logic                      halt,
    output logic                      done
);

    simproc_pkg::core_state_t state;
    simproc_pkg::core_state_t next_state;

    // Datapath registers
    simproc_pkg::word_t ir;
    simproc_pkg::word_t opnd_a;
    simproc_pkg::word_t opnd_b;
    simproc_pkg::word_t mdr;
    simproc_pkg::word_t alu_reg;
    logic               n_flag;
    logic               z_flag;

    // Register load strobes
    simproc_pkg::word_t pc_next;
    logic               pc_wr;
    logic               ir_load;
    logic               ab_load;
    logic               mdr_load;
    logic               res_load;
    logic               flag_wr;

    // Instruction decode
    simproc_pkg::opcode_t opc;
    logic                 is_arith;
    logic                 is_shift;
    logic                 is_ori;
    logic                 is_branch;
    logic                 take_branch;

    always_comb begin
        opc       = simproc_pkg::opcode_t'(ir[3:0]);
        is_arith  = (opc == simproc_pkg::OP_ADD) || (opc == simproc_pkg::OP_SUB) ||
                    (opc == simproc_pkg::OP_NAND);
        is_shift  = (ir[2:0] == 3'(simproc_pkg::OP_SHIFT));
        is_ori    = (ir[2:0] == 3'(simproc_pkg::OP_ORI));
        is_branch = (opc == simproc_pkg::OP_BZ) || (opc == simproc_pkg::OP_BNZ) ||
                    (opc == simproc_pkg::OP_BPZ) || (opc == simproc_pkg::OP_JUMP);

        case (opc)
            simproc_pkg::OP_BZ:   take_branch = z_flag;
            simproc_pkg::OP_BNZ:  take_branch = !z_flag;
            simproc_pkg::OP_BPZ:  take_branch = !n_flag;
            simproc_pkg::OP_JUMP: take_branch = 1'b1;
            default:              take_branch = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        done       = 1'b0;
        halt       = 1'b0;
        pc_next    = alu_result;
        pc_wr      = 1'b0;
        mem.addr   = '0;
        mem.din    = '0;
        mem.we     = 1'b0;
        rf.idx_a   = '0;
        rf.idx_b   = '0;
        rf.idx_w   = '0;
        rf.wdata   = '0;
        rf.we      = 1'b0;
        alu_op     = simproc_pkg::ALU_ADD;
        alu_a      = '0;
        alu_b      = '0;
        ir_load    = 1'b0;
        ab_load    = 1'b0;
        mdr_load   = 1'b0;
        res_load   = 1'b0;
        flag_wr    = 1'b0;

        case (state)
            simproc_pkg::IDLE: begin
                halt    = 1'b1;
                pc_next = pc_set_val;
                pc_wr   = pc_set_wr;
                if (run) begin
                    next_state = simproc_pkg::CYCLE_1;
                end
            end

            simproc_pkg::CYCLE_1: begin
                // Fetch, PC+1 through the ALU
                mem.addr   = pc;
                ir_load    = 1'b1;
                alu_a      = pc;
                alu_b      = simproc_pkg::word_t'(1);
                pc_wr      = 1'b1;
                next_state = simproc_pkg::CYCLE_2;
            end

            simproc_pkg::CYCLE_2: begin
                rf.idx_a   = ir[7:6];
                rf.idx_b   = ir[5:4];
                ab_load    = 1'b1;
                next_state = simproc_pkg::CYCLE_3;
            end

            simproc_pkg::CYCLE_3: begin
                // Unknown opcodes fall back to idle with no done
                next_state = simproc_pkg::IDLE;
                if (is_arith) begin
                    case (opc)
                        simproc_pkg::OP_SUB:  alu_op = simproc_pkg::ALU_SUB;
                        simproc_pkg::OP_NAND: alu_op = simproc_pkg::ALU_NAND;
                        default:              alu_op = simproc_pkg::ALU_ADD;
                    endcase
                    alu_a      = opnd_a;
                    alu_b      = opnd_b;
                    res_load   = 1'b1;
                    flag_wr    = 1'b1;
                    next_state = simproc_pkg::CYCLE_4;
                end
                else if (is_shift) begin
                    alu_op     = ir[5] ? simproc_pkg::ALU_SHL : simproc_pkg::ALU_SHR;
                    alu_a      = opnd_a;
                    alu_b      = {{(`SIMPROC_DATA_WIDTH-2){1'b0}}, ir[4:3]};
                    res_load   = 1'b1;
                    flag_wr    = 1'b1;
                    next_state = simproc_pkg::CYCLE_4;
                end
                else if (opc == simproc_pkg::OP_LOAD) begin
                    mem.addr   = opnd_b;
                    mdr_load   = 1'b1;
                    next_state = simproc_pkg::CYCLE_4;
                end
                else if (opc == simproc_pkg::OP_STORE) begin
                    mem.addr = opnd_b;
                    mem.din  = opnd_a;
                    mem.we   = 1'b1;
                    done     = 1'b1;
                end
                else if (is_branch) begin
                    // PC already points past the branch
                    alu_a = pc;
                    alu_b = {{(`SIMPROC_DATA_WIDTH-4){ir[7]}}, ir[7:4]};
                    pc_wr = take_branch;
                    done  = 1'b1;
                end
                else if (is_ori) begin
                    // Reload A with register 0
                    rf.idx_a   = '0;
                    rf.idx_b   = ir[5:4];
                    ab_load    = 1'b1;
                    next_state = simproc_pkg::CYCLE_4;
                end
            end

            simproc_pkg::CYCLE_4: begin
                next_state = simproc_pkg::IDLE;
                if (is_arith || is_shift) begin
                    rf.idx_w = ir[7:6];
                    rf.wdata = alu_reg;
                    rf.we    = 1'b1;
                    done     = 1'b1;
                end
                else if (opc == simproc_pkg::OP_LOAD) begin
                    rf.idx_w = ir[7:6];
                    rf.wdata = mdr;
                    rf.we    = 1'b1;
                    done     = 1'b1;
                end
                else if (is_ori) begin
                    alu_op     = simproc_pkg::ALU_OR;
                    alu_a      = opnd_a;
                    alu_b      = {{(`SIMPROC_DATA_WIDTH-5){1'b0}}, ir[7:3]};
                    res_load   = 1'b1;
                    flag_wr    = 1'b1;
                    next_state = simproc_pkg::CYCLE_5;
                end
            end

            simproc_pkg::CYCLE_5: begin
                // ORI write-back into register 0
                rf.idx_w = '0;
                rf.wdata = alu_reg;
                rf.we    = 1'b1;
                done     = 1'b1;
            end

            default: begin
                next_state = simproc_pkg::IDLE;
            end
        endcase

        // Last cycle of an instruction chains into the next one while run is high
        if (done) begin
            next_state = run ? simproc_pkg::CYCLE_1 : simproc_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= simproc_pkg::IDLE;
            pc      <= '0;
            ir      <= '0;
            opnd_a  <= '0;
            opnd_b  <= '0;
            mdr     <= '0;
            alu_reg <= '0;
            n_flag  <= 1'b0;
            z_flag  <= 1'b0;
        end
        else begin
            state <= next_state;
            if (pc_wr) begin
                pc <= pc_next;
            end
            if (ir_load) begin
                ir <= mem.dout;
            end
            if (ab_load) begin
                opnd_a <= rf.rdata_a;
                opnd_b <= rf.rdata_b;
            end
            if (mdr_load) begin
                mdr <= mem.dout;
            end
            if (res_load) begin
                alu_reg <= alu_result;
            end
            if (flag_wr) begin
                n_flag <= alu_n;
                z_flag <= alu_z;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/simproc_top.sv
`default_nettype none
`timescale 1ns/1ps

module simproc_top (
    input  wire logic               clk,
    input  wire logic               rst,
    // Host access to memory port B
    input  wire simproc_pkg::word_t host_addr,
    input  wire simproc_pkg::word_t host_din,
    input  wire logic               host_we,
    output simproc_pkg::word_t      host_dout,
    // Debug controls
    input  wire simproc_pkg::word_t pc_set_val,
    input  wire logic               pc_set_wr,
    input  wire logic               run,
    output simproc_pkg::word_t      pc,
    output logic                    halt,
    output logic                    done
);

    mem_port_if mem_bus ();
    rf_port_if  rf_bus ();

    simproc_pkg::alu_op_t alu_op;
    simproc_pkg::word_t   alu_a;
    simproc_pkg::word_t   alu_b;
    simproc_pkg::word_t   alu_result;
    logic                 alu_n;
    logic                 alu_z;

    simproc_core u_core (
        .clk        (clk),
        .rst        (rst),
        .mem        (mem_bus.core),
        .rf         (rf_bus.core),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_n      (alu_n),
        .alu_z      (alu_z),
        .pc_set_val (pc_set_val),
        .pc_set_wr  (pc_set_wr),
        .run        (run),
        .pc         (pc),
        .halt       (halt),
        .done       (done)
    );

    register_file u_rf (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus.regfile)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .n      (alu_n),
        .z      (alu_z)
    );

    dp_ram u_ram (
        .clk       (clk),
        .mem       (mem_bus.memory),
        .host_addr (host_addr),
        .host_din  (host_din),
        .host_we   (host_we),
        .host_dout (host_dout)
    );

endmodule

`default_nettype wire

// File: testbench/tb_simproc.sv
`default_nettype none
`timescale 1ns/1ps

module tb_simproc;

    // Cycle budget for any single wait
    localparam int WAIT_LIMIT = 1000;

    logic               clk;
    logic               rst;
    simproc_pkg::word_t host_addr;
    simproc_pkg::word_t host_din;
    logic               host_we;
    simproc_pkg::word_t host_dout;
    simproc_pkg::word_t pc_set_val;
    logic               pc_set_wr;
    logic               run;
    simproc_pkg::word_t pc;
    logic               halt;
    logic               done;

    // Records of three bytes each for command, address and value
    logic [7:0] testdata [512];

    simproc_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .host_addr  (host_addr),
        .host_din   (host_din),
        .host_we    (host_we),
        .host_dout  (host_dout),
        .pc_set_val (pc_set_val),
        .pc_set_wr  (pc_set_wr),
        .run        (run),
        .pc         (pc),
        .halt       (halt),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input simproc_pkg::word_t actual,
                              input simproc_pkg::word_t expected,
                              input string what);
        if (actual !== expected) begin
            fail_stop($sformatf("ERR %0t: %s is 0x%02h, expected 0x%02h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_stop($sformatf("ERR %0t: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    // All host tasks start and end just after a falling edge
    task automatic write_mem(input simproc_pkg::word_t addr, input simproc_pkg::word_t value);
        host_addr = addr;
        host_din  = value;
        host_we   = 1'b1;
        @(negedge clk);
        host_we   = 1'b0;
    endtask

    task automatic read_check_mem(input simproc_pkg::word_t addr,
                                  input simproc_pkg::word_t expected);
        host_addr = addr;
        @(negedge clk);
        check_word(host_dout, expected, $sformatf("memory[0x%02h]", addr));
    endtask

    task automatic set_pc(input simproc_pkg::word_t value);
        check_bit(halt, 1'b1, "halt before PC set");
        pc_set_val = value;
        pc_set_wr  = 1'b1;
        @(negedge clk);
        pc_set_wr  = 1'b0;
    endtask

    task automatic wait_for_halt(input string what);
        int cycles;
        cycles = 0;
        while (halt !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                fail_stop({"Timeout: halt did not return ", what});
            end
            else begin
                @(negedge clk);
                cycles++;
            end
        end
        check_bit(done, 1'b0, "done once halted");
    endtask

    // One-cycle run pulse followed by exactly one done pulse
    task automatic step_once();
        int cycles;
        check_bit(halt, 1'b1, "halt before step");
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                fail_stop("Timeout: no done pulse after a single step");
            end
            else begin
                @(negedge clk);
                cycles++;
            end
        end
        check_bit(halt, 1'b0, "halt in the done cycle");
        @(negedge clk);
        check_bit(done, 1'b0, "done one cycle after the step");
        check_bit(halt, 1'b1, "halt one cycle after the step");
    endtask

    // Hold run high and count done pulses
    task automatic run_for_count(input int count);
        int seen;
        int cycles;
        check_bit(halt, 1'b1, "halt before run");
        run    = 1'b1;
        seen   = 0;
        cycles = 0;
        while (seen < count) begin
            if (cycles == WAIT_LIMIT) begin
                fail_stop($sformatf("Timeout: done pulse %0d of %0d never came while running",
                                    seen + 1, count));
            end
            else begin
                @(negedge clk);
                cycles++;
                check_bit(halt, 1'b0, "halt while running");
                if (done === 1'b1) begin
                    seen++;
                    cycles = 0;
                end
            end
        end
        run = 1'b0;
        wait_for_halt("after the continuous run");
    endtask

    initial begin
        logic [8:0] pos;
        logic [7:0] cmd;
        logic [7:0] addr_f;
        logic [7:0] val_f;
        logic       finished;

        rst        = 1'b1;
        host_addr  = '0;
        host_din   = '0;
        host_we    = 1'b0;
        pc_set_val = '0;
        pc_set_wr  = 1'b0;
        run        = 1'b0;
        $readmemh("testbench/simproc_testdata.txt", testdata);

        // Ten rising edges with reset high
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit(halt, 1'b1, "halt after reset");
        check_bit(done, 1'b0, "done after reset");
        check_word(pc, 8'h00, "pc after reset");

        pos      = '0;
        finished = 1'b0;
        while (!finished) begin
            if (pos > 9'd507) begin
                fail_stop("Test data ran out without an end record");
            end
            else begin
                cmd    = testdata[pos];
                addr_f = testdata[pos + 9'd1];
                val_f  = testdata[pos + 9'd2];
                pos    = pos + 9'd3;
                case (cmd)
                    8'h00: finished = 1'b1;
                    8'h01: write_mem(addr_f, val_f);
                    8'h02: read_check_mem(addr_f, val_f);
                    8'h03: set_pc(val_f);
                    8'h04: step_once();
                    8'h05: run_for_count(int'(val_f));
                    8'h06: check_word(pc, val_f, "pc");
                    default: begin
                        fail_stop($sformatf("Unknown command 0x%02h in the test data", cmd));
                    end
                endcase
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/simproc_testdata.txt
// Columns: command address value, all hex, one or more records per line
// 01 write mem, 02 check mem, 03 set PC, 04 step, 05 run for value done pulses, 06 check PC, 00 end

// Host memory port, 81 rewritten while its neighbours stay
01 80 a5
01 81 5a
01 82 c3
01 81 3e
02 80 a5
02 81 3e
02 82 c3

// Single step of ORI r0, 0x10 at 0x40
01 40 87
03 00 40  06 00 40
04 00 00  06 00 41

// Operands and pointer table
01 10 3c
01 11 25
01 13 20
01 17 01

// Arithmetic program from 0x41, 24 instructions
01 41 80  01 42 0f  01 43 c0  01 44 17
01 45 40  01 46 27  01 47 00
01 48 b4  01 49 92  01 4a 44
01 4b b6  01 4c 92  01 4d 44
01 4e b8  01 4f 92  01 50 44
01 51 b3  01 52 92  01 53 44
01 54 cb  01 55 d2  01 56 44
01 57 f7  01 58 12
05 00 18
06 00 59
02 20 61
02 21 3c
02 22 db
02 23 6c
02 24 12
02 25 1f

// Branches, stepped with the PC checked after each
01 60 f6  01 61 2a  01 64 39  01 65 15  01 67 a8
01 68 25  01 69 2a  01 6a 19  01 6c 81
03 00 60
04 00 00  06 00 61
04 00 00  06 00 64
04 00 00  06 00 65
04 00 00  06 00 67
04 00 00  06 00 68
04 00 00  06 00 69
04 00 00  06 00 6a
04 00 00  06 00 6c
04 00 00  06 00 65

// Shift loop summing r0 into r3, run continuously for 16 instructions
01 70 c4  01 71 0b  01 72 d9  01 73 d2
03 00 70
05 00 10
06 00 74
02 25 39

00 00 00

// File: vlog.f
+incdir+rtl
rtl/simproc_pkg.sv
rtl/simproc_if.sv
rtl/dp_ram.sv
rtl/register_file.sv
rtl/alu.sv
rtl/simproc_core.sv
rtl/simproc_top.sv
testbench/tb_simproc.sv

// File: Makefile
TOP = tb_simproc

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
